// ==== sources.f ====
+incdir+sim
hdl/rv_core_pkg.sv
hdl/rv_decode.sv
hdl/rv_regfile.sv
hdl/rv_alu.sv
hdl/rv_branch_cmp.sv
hdl/rv_commit.sv
hdl/rv_core_top.sv
sim/tb_rv_core.sv

// ==== Makefile ====
VERILATOR       ?= verilator
TOP             ?= tb_rv_core
FILELIST        ?= sources.f
BUILD_DIR       ?= obj_dir
LOG             ?= sim.log
VERILATOR_FLAGS ?= --binary --timing -Wno-fatal

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard sim/*.svh)

.PHONY: all run clean

all: run

$(SIM_BIN): $(FILELIST) $(SOURCES) $(HEADERS)
	$(VERILATOR) $(VERILATOR_FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -qx "test passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== sim/rv_iss_model.svh ====
`ifndef rv_iss_model_svh
`define rv_iss_model_svh

word_t    ref_regs [32]; // architectural state of the model
word_t    ref_pc;
opcode_t  gen_opc;       // intended operation of the current instruction
funct3_t  gen_f3;
logic     gen_alt;
reg_idx_t gen_rd;
reg_idx_t gen_rs1;
reg_idx_t gen_rs2;
word_t    gen_imm;

task automatic reset_model();
  foreach (ref_regs[i]) begin
    ref_regs[i] = '0;
  end
  ref_pc = reset_pc_default;
endtask

// RV32I integer semantics where sub_sra picks sub or sra
function automatic word_t alu_ref(funct3_t f3, logic sub_sra, word_t a, word_t b);
  word_t fill;
  fill = a[31] ? ~(32'hffff_ffff >> b[4:0]) : '0; // sign bits shifted in
  case (f3)
    f3_add:  return sub_sra ? a - b : a + b;
    f3_sll:  return a << b[4:0];
    f3_slt:  return word_t'((a ^ 32'h8000_0000) < (b ^ 32'h8000_0000));
    f3_sltu: return word_t'(a < b);
    f3_xor:  return a ^ b;
    f3_srl:  return (a >> b[4:0]) | (sub_sra ? fill : '0);
    f3_or:   return a | b;
    default: return a & b;
  endcase
endfunction

function automatic logic taken_ref(funct3_t f3, word_t a, word_t b);
  case (f3)
    f3_beq:  return a == b;
    f3_bne:  return a != b;
    f3_blt:  return (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000);
    f3_bge:  return (a ^ 32'h8000_0000) >= (b ^ 32'h8000_0000);
    f3_bltu: return a < b;
    default: return a >= b;
  endcase
endfunction

task automatic predict(output logic exp_en, output word_t exp_data, output word_t exp_next);
  word_t a;
  word_t b;
  a        = ref_regs[gen_rs1];
  b        = ref_regs[gen_rs2];
  exp_en   = 1'b1;
  exp_data = '0;
  exp_next = ref_pc + 32'd4;
  case (gen_opc)
    op_op:     exp_data = alu_ref(gen_f3, gen_alt, a, b);
    op_op_imm: exp_data = alu_ref(gen_f3, gen_alt, a, gen_imm);
    op_lui:    exp_data = gen_imm;
    op_auipc:  exp_data = ref_pc + gen_imm;
    op_jal: begin
      exp_data = ref_pc + 32'd4;
      exp_next = ref_pc + gen_imm;
    end
    op_jalr: begin
      exp_data = ref_pc + 32'd4;
      exp_next = (a + gen_imm) & ~32'd1; // lsb of the target dropped
    end
    op_branch: begin
      exp_en = 1'b0;
      if (taken_ref(gen_f3, a, b)) begin
        exp_next = ref_pc + gen_imm;
      end
    end
    default: exp_en = 1'b0; // load, store, system and the rest do nothing
  endcase
endtask

task automatic retire(logic en, word_t data, word_t next);
  if (en && gen_rd != 0) begin
    ref_regs[gen_rd] = data;
  end
  ref_pc = next;
endtask

`endif

// ==== sim/tb_rv_core.sv ====
module tb_rv_core import rv_core_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int num_instr    = 2000;
  localparam int reset_cycles = 16;
  localparam int max_cycles   = num_instr + reset_cycles + 100;

  logic     clk = 1'b0;
  logic     rst_n;
  word_t    imem_data;
  word_t    imem_addr;
  word_t    wb_data;
  logic     wb_en;
  reg_idx_t wb_addr;

  int    error_count = 0;
  int    check_count = 0;
  int    cycle_count = 0;
  word_t instr;
  logic  exp_en;
  word_t exp_data;
  word_t exp_next;

  `include "rv_iss_model.svh"

  rv_core_top i_rv_core_top (
    .clk       (clk),
    .rst_n     (rst_n),
    .imem_data (imem_data),
    .imem_addr (imem_addr),
    .wb_data   (wb_data),
    .wb_en     (wb_en),
    .wb_addr   (wb_addr)
  );

  always #2 clk = ~clk; // 4 ns period

  task automatic check_value(string name, word_t got, word_t exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("Error: %s is %h, expected %h", name, got, exp);
    end
  endtask

  // random instruction weighted towards alu work
  task automatic pick_instr(output word_t word);
    int unsigned roll;
    logic [19:0] r20; // raw immediate bits
    roll    = $urandom_range(99);
    r20     = 20'($urandom);
    gen_rd  = ($urandom_range(7) == 0) ? 5'd0 : 5'($urandom);
    gen_rs1 = 5'($urandom);
    gen_rs2 = 5'($urandom);
    gen_f3  = 3'($urandom);
    gen_alt = 1'b0;
    gen_imm = {{20{r20[11]}}, r20[11:0]}; // I immediate unless changed below
    if (roll < 30) begin
      gen_opc = op_op;
      gen_alt = (gen_f3 == f3_add || gen_f3 == f3_srl) && $urandom_range(1) == 1;
      word    = {1'b0, gen_alt, 5'd0, gen_rs2, gen_rs1, gen_f3, gen_rd, gen_opc};
    end else if (roll < 60) begin
      gen_opc = op_op_imm;
      if (gen_f3 == f3_sll || gen_f3 == f3_srl) begin
        gen_alt = gen_f3 == f3_srl && $urandom_range(1) == 1; // srai
        gen_imm = {27'd0, r20[4:0]};
        word    = {1'b0, gen_alt, 5'd0, r20[4:0], gen_rs1, gen_f3, gen_rd, gen_opc};
      end else begin
        word = {r20[11:0], gen_rs1, gen_f3, gen_rd, gen_opc};
      end
    end else if (roll < 70) begin
      gen_opc = ($urandom_range(1) == 1) ? op_lui : op_auipc;
      gen_imm = {r20, 12'h000};
      word    = {r20, gen_rd, gen_opc};
    end else if (roll < 76) begin
      gen_opc = op_jal;
      gen_imm = {{11{r20[19]}}, r20, 1'b0};
      word    = {r20[19], r20[9:0], r20[10], r20[18:11], gen_rd, gen_opc};
    end else if (roll < 82) begin
      gen_opc = op_jalr;
      gen_f3  = 3'b000;
      word    = {r20[11:0], gen_rs1, gen_f3, gen_rd, gen_opc};
    end else if (roll < 94) begin
      gen_opc = op_branch;
      while (gen_f3 == 3'b010 || gen_f3 == 3'b011) begin
        gen_f3 = 3'($urandom);
      end
      if ($urandom_range(3) == 0) begin
        gen_rs2 = gen_rs1; // equal operands so eq conditions hit
      end
      gen_imm = {{19{r20[11]}}, r20[11:0], 1'b0};
      word    = {r20[11], r20[9:4], gen_rs2, gen_rs1, gen_f3, r20[3:0], r20[10], gen_opc};
    end else begin
      case ($urandom_range(3))
        0: gen_opc = 7'b000_0011; // load
        1: gen_opc = 7'b010_0011; // store
        2: gen_opc = 7'b111_0011; // system
        default: begin
          gen_opc = 7'($urandom);
          while (gen_opc inside {op_op, op_op_imm, op_lui, op_auipc,
                                 op_jal, op_jalr, op_branch}) begin
            gen_opc = 7'($urandom);
          end
        end
      endcase
      word      = word_t'($urandom);
      word[6:0] = gen_opc;
    end
  endtask

  initial begin
    void'($urandom(69340));
    rst_n     = 1'b0;
    imem_data = '0;
    reset_model();
    repeat (reset_cycles) begin
      @(negedge clk);
      check_value("imem_addr", imem_addr, reset_pc_default);
      check_value("wb_en", word_t'(wb_en), '0);
    end
    rst_n = 1'b1; // first instruction retires at the next rising edge
    for (int n = 0; n < num_instr; n++) begin
      pick_instr(instr);
      imem_data = instr;
      #1;
      predict(exp_en, exp_data, exp_next);
      check_value("imem_addr", imem_addr, ref_pc);
      check_value("wb_en", word_t'(wb_en), word_t'(exp_en));
      if (exp_en) begin
        check_value("wb_addr", word_t'(wb_addr), word_t'(gen_rd));
        check_value("wb_data", wb_data, exp_data);
      end
      retire(exp_en, exp_data, exp_next);
      @(negedge clk);
    end
    imem_data = '0;
    check_value("imem_addr", imem_addr, ref_pc); // pc after the last instruction
    $display("checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  // guards against a stuck run
  initial begin
    while (cycle_count < max_cycles) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout: the run did not finish within %0d cycles", max_cycles);
    $display("test failed");
    $finish;
  end

endmodule

// ==== hdl/rv_core_top.sv ====
module rv_core_top import rv_core_pkg::*; #(
  parameter word_t reset_pc = reset_pc_default,
  parameter int    num_regs = 32
) (
  input  logic     clk,
  input  logic     rst_n,
  input  word_t    imem_data,
  output word_t    imem_addr,
  output word_t    wb_data,
  output logic     wb_en,
  output reg_idx_t wb_addr
);

  // decoded fields
  reg_idx_t rs1_idx;
  reg_idx_t rs2_idx;
  reg_idx_t rd_idx;
  funct3_t  funct3;
  logic     alt_op;
  logic     use_imm;
  logic     reg_write;
  logic     is_lui;
  logic     is_auipc;
  logic     is_jal;
  logic     is_jalr;
  logic     is_branch;
  word_t    alu_imm;
  word_t    ctl_imm;

  // operands and results
  word_t rs1_data;
  word_t rs2_data;
  word_t alu_result;
  logic  cond_true;

  rv_decode i_rv_decode (
    .instr     (imem_data),
    .rs1_idx   (rs1_idx),
    .rs2_idx   (rs2_idx),
    .rd_idx    (rd_idx),
    .funct3    (funct3),
    .alt_op    (alt_op),
    .use_imm   (use_imm),
    .reg_write (reg_write),
    .is_lui    (is_lui),
    .is_auipc  (is_auipc),
    .is_jal    (is_jal),
    .is_jalr   (is_jalr),
    .is_branch (is_branch),
    .alu_imm   (alu_imm),
    .ctl_imm   (ctl_imm)
  );

  // write port fed straight from the commit outputs
  rv_regfile #(
    .num_regs (num_regs)
  ) i_rv_regfile (
    .clk      (clk),
    .rst_n    (rst_n),
    .rs1_idx  (rs1_idx),
    .rs2_idx  (rs2_idx),
    .wr_idx   (wb_addr),
    .wr_en    (wb_en),
    .wr_data  (wb_data),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  rv_alu i_rv_alu (
    .rs1_data   (rs1_data),
    .rs2_data   (rs2_data),
    .alu_imm    (alu_imm),
    .use_imm    (use_imm),
    .alt_op     (alt_op),
    .funct3     (funct3),
    .alu_result (alu_result)
  );

  rv_branch_cmp i_rv_branch_cmp (
    .rs1_data  (rs1_data),
    .rs2_data  (rs2_data),
    .funct3    (funct3),
    .cond_true (cond_true)
  );

  rv_commit #(
    .reset_pc (reset_pc)
  ) i_rv_commit (
    .clk        (clk),
    .rst_n      (rst_n),
    .is_lui     (is_lui),
    .is_auipc   (is_auipc),
    .is_jal     (is_jal),
    .is_jalr    (is_jalr),
    .is_branch  (is_branch),
    .reg_write  (reg_write),
    .cond_true  (cond_true),
    .rd_idx     (rd_idx),
    .ctl_imm    (ctl_imm),
    .alu_result (alu_result),
    .rs1_data   (rs1_data),
    .pc         (imem_addr), // fetch address is the pc itself
    .wb_data    (wb_data),
    .wb_en      (wb_en),
    .wb_addr    (wb_addr)
  );

endmodule

// ==== hdl/rv_commit.sv ====
module rv_commit import rv_core_pkg::*; #(
  parameter word_t reset_pc = reset_pc_default
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     is_lui,
  input  logic     is_auipc,
  input  logic     is_jal,
  input  logic     is_jalr,
  input  logic     is_branch,
  input  logic     reg_write,
  input  logic     cond_true,
  input  reg_idx_t rd_idx,
  input  word_t    ctl_imm,
  input  word_t    alu_result,
  input  word_t    rs1_data,
  output word_t    pc,
  output word_t    wb_data,
  output logic     wb_en,
  output reg_idx_t wb_addr
);

  word_t pc_plus4;
  word_t tgt_base;
  word_t tgt_sum;
  word_t target;
  word_t next_pc;
  logic  redirect;

  assign pc_plus4 = pc + 32'd4;

  // jalr is relative to rs1, everything else to the pc
  assign tgt_base = is_jalr ? rs1_data : pc;
  assign tgt_sum  = tgt_base + ctl_imm;
  assign target   = is_jalr ? {tgt_sum[31:1], 1'b0} : tgt_sum;

  // taken control transfer
  assign redirect = is_jal || is_jalr || (is_branch && cond_true);
  assign next_pc  = redirect ? target : pc_plus4;

  always_comb begin
    if (is_lui) begin
      wb_data = ctl_imm;
    end else if (is_auipc) begin
      wb_data = target; // pc + U immediate
    end else if (is_jal || is_jalr) begin
      wb_data = pc_plus4; // link address
    end else begin
      wb_data = alu_result;
    end
  end

  assign wb_en   = reg_write;
  assign wb_addr = rd_idx;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc <= reset_pc;
    end else begin
      pc <= next_pc;
    end
  end

endmodule

// ==== hdl/rv_branch_cmp.sv ====
module rv_branch_cmp import rv_core_pkg::*; (
  input  word_t   rs1_data,
  input  word_t   rs2_data,
  input  funct3_t funct3,
  output logic    cond_true
);

  logic eq;
  logic lt_s;
  logic lt_u;

  // one compare of each kind shared by the six conditions
  assign eq   = rs1_data == rs2_data;
  assign lt_s = $signed(rs1_data) < $signed(rs2_data);
  assign lt_u = rs1_data < rs2_data;

  always_comb begin
    case (funct3)
      f3_beq:  cond_true = eq;
      f3_bne:  cond_true = !eq;
      f3_blt:  cond_true = lt_s;
      f3_bge:  cond_true = !lt_s;
      f3_bltu: cond_true = lt_u;
      f3_bgeu: cond_true = !lt_u;
      default: cond_true = 1'b0; // reserved encodings never branch
    endcase
  end

endmodule

// ==== hdl/rv_alu.sv ====
module rv_alu import rv_core_pkg::*; (
  input  word_t   rs1_data,
  input  word_t   rs2_data,
  input  word_t   alu_imm,
  input  logic    use_imm,
  input  logic    alt_op,
  input  funct3_t funct3,
  output word_t   alu_result
);

  word_t      op_b;
  logic [4:0] shamt;
  logic       do_sub;
  word_t      add_sub;
  logic       lt_s;
  logic       lt_u;

  assign op_b  = use_imm ? alu_imm : rs2_data;
  assign shamt = op_b[4:0]; // only the low 5 bits shift

  // addi never subtracts even with bit 30 set
  assign do_sub  = alt_op && !use_imm;
  assign add_sub = do_sub ? rs1_data - op_b : rs1_data + op_b;

  assign lt_s = $signed(rs1_data) < $signed(op_b);
  assign lt_u = rs1_data < op_b;

  always_comb begin
    case (funct3)
      f3_add:  alu_result = add_sub;
      f3_sll:  alu_result = rs1_data << shamt;
      f3_slt:  alu_result = {31'd0, lt_s};
      f3_sltu: alu_result = {31'd0, lt_u};
      f3_xor:  alu_result = rs1_data ^ op_b;
      f3_srl: begin
        if (alt_op) begin
          alu_result = word_t'($signed(rs1_data) >>> shamt); // sign fill
        end else begin
          alu_result = rs1_data >> shamt;
        end
      end
      f3_or:   alu_result = rs1_data | op_b;
      f3_and:  alu_result = rs1_data & op_b;
      default: alu_result = '0;
    endcase
  end

endmodule

// ==== hdl/rv_regfile.sv ====
module rv_regfile import rv_core_pkg::*; #(
  parameter int num_regs = 32
) (
  input  logic     clk,
  input  logic     rst_n,
  input  reg_idx_t rs1_idx,
  input  reg_idx_t rs2_idx,
  input  reg_idx_t wr_idx,
  input  logic     wr_en,
  input  word_t    wr_data,
  output word_t    rs1_data,
  output word_t    rs2_data
);

  word_t regs [1:num_regs-1]; // x0 has no storage

  // x0 and indices past the array read as zero
  assign rs1_data = (rs1_idx != 0 && rs1_idx < num_regs) ? regs[rs1_idx] : '0;
  assign rs2_data = (rs2_idx != 0 && rs2_idx < num_regs) ? regs[rs2_idx] : '0;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 1; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en && wr_idx != 0 && wr_idx < num_regs) begin
      regs[wr_idx] <= wr_data;
    end
  end

endmodule

// ==== hdl/rv_decode.sv ====
module rv_decode import rv_core_pkg::*; (
  input  word_t    instr,
  output reg_idx_t rs1_idx,
  output reg_idx_t rs2_idx,
  output reg_idx_t rd_idx,
  output funct3_t  funct3,
  output logic     alt_op,
  output logic     use_imm,
  output logic     reg_write,
  output logic     is_lui,
  output logic     is_auipc,
  output logic     is_jal,
  output logic     is_jalr,
  output logic     is_branch,
  output word_t    alu_imm,
  output word_t    ctl_imm
);

  opcode_t opcode;
  word_t   imm_i;
  word_t   imm_u;
  word_t   imm_j;
  word_t   imm_b;
  logic    is_shift; // sll or srl/sra encoding
  logic    is_op;
  logic    is_op_imm;

  // fixed field positions
  assign opcode  = instr[6:0];
  assign rd_idx  = instr[11:7];
  assign funct3  = instr[14:12];
  assign rs1_idx = instr[19:15];
  assign rs2_idx = instr[24:20];

  // sign-extended immediates
  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_u = {instr[31:12], 12'h000};
  assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
  assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};

  assign is_shift = (funct3 == f3_sll) || (funct3 == f3_srl);

  // slli/srli/srai only take the shamt field
  assign alu_imm = is_shift ? {27'd0, instr[24:20]} : imm_i;

  // unknown opcodes leave every control level low
  always_comb begin
    is_op     = 1'b0;
    is_op_imm = 1'b0;
    is_lui    = 1'b0;
    is_auipc  = 1'b0;
    is_jal    = 1'b0;
    is_jalr   = 1'b0;
    is_branch = 1'b0;
    ctl_imm   = imm_i;
    case (opcode)
      op_op:     is_op     = 1'b1;
      op_op_imm: is_op_imm = 1'b1;
      op_lui: begin
        is_lui  = 1'b1;
        ctl_imm = imm_u;
      end
      op_auipc: begin
        is_auipc = 1'b1;
        ctl_imm  = imm_u;
      end
      op_jal: begin
        is_jal  = 1'b1;
        ctl_imm = imm_j;
      end
      op_jalr:   is_jalr = 1'b1; // base is rs1, I immediate
      op_branch: begin
        is_branch = 1'b1;
        ctl_imm   = imm_b;
      end
      default: ;
    endcase
  end

  assign use_imm = is_op_imm;

  // sub only exists in the register form, sra/srai in both
  assign alt_op = instr[alt_bit_pos] &&
                  ((is_op && (funct3 == f3_add)) ||
                   ((is_op || is_op_imm) && (funct3 == f3_srl)));

  assign reg_write = is_op | is_op_imm | is_lui | is_auipc | is_jal | is_jalr;

endmodule

// ==== hdl/rv_core_pkg.sv ====
package rv_core_pkg;

  // architectural widths
  typedef logic [31:0] word_t;    // data word or address
  typedef logic [4:0]  reg_idx_t; // register number
  typedef logic [6:0]  opcode_t;  // major opcode
  typedef logic [2:0]  funct3_t;  // minor operation

  // major opcodes handled by the core
  localparam opcode_t op_op     = 7'b011_0011; // register-register
  localparam opcode_t op_op_imm = 7'b001_0011; // register-immediate
  localparam opcode_t op_lui    = 7'b011_0111;
  localparam opcode_t op_auipc  = 7'b001_0111;
  localparam opcode_t op_jal    = 7'b110_1111;
  localparam opcode_t op_jalr   = 7'b110_0111;
  localparam opcode_t op_branch = 7'b110_0011;

  // alu funct3
  localparam funct3_t f3_add  = 3'b000; // add, sub, addi
  localparam funct3_t f3_sll  = 3'b001;
  localparam funct3_t f3_slt  = 3'b010;
  localparam funct3_t f3_sltu = 3'b011;
  localparam funct3_t f3_xor  = 3'b100;
  localparam funct3_t f3_srl  = 3'b101; // srl and sra
  localparam funct3_t f3_or   = 3'b110;
  localparam funct3_t f3_and  = 3'b111;

  // branch funct3 with 010 and 011 reserved
  localparam funct3_t f3_beq  = 3'b000;
  localparam funct3_t f3_bne  = 3'b001;
  localparam funct3_t f3_blt  = 3'b100;
  localparam funct3_t f3_bge  = 3'b101;
  localparam funct3_t f3_bltu = 3'b110;
  localparam funct3_t f3_bgeu = 3'b111;

  // funct7 bit picking sub / sra
  localparam int alt_bit_pos = 30;

  localparam word_t reset_pc_default = 32'h8000_0000;

endpackage
